//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
LOG       ?= sim.log
BUILD     ?= obj_dir
FLIST     ?= tb.f

.PHONY: sim clean

sim:
	$(VERILATOR) --binary -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- controller.sv
`timescale 1ns/1ps

module controller (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic [rv_pkg::xlen-1:0] instr_d,
  input  logic                    zero_e,
  input  rv_pkg::hazard_t         hz,
  output rv_pkg::imm_sel_e        imm_sel,
  output rv_pkg::ex_ctrl_t        ex_ctrl,
  output rv_pkg::mem_ctrl_t       mem_ctrl,
  output rv_pkg::wb_ctrl_t        wb_ctrl,
  output logic                    pc_redirect
);
  import rv_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic       funct7_5;
  ex_ctrl_t   ctrl_d;

  assign opcode   = opcode_e'(instr_d[6:0]);
  assign funct3   = instr_d[14:12];
  assign funct7_5 = instr_d[30];

  // main decode
  always_comb begin
    ctrl_d            = '0;
    ctrl_d.alu_op     = alu_add;
    ctrl_d.result_sel = res_alu;
    imm_sel           = imm_i;
    case (opcode)
      opc_op: begin
        ctrl_d.reg_write = 1'b1;
        case (funct3)
          3'b000:  ctrl_d.alu_op = funct7_5 ? alu_sub : alu_add;
          3'b010:  ctrl_d.alu_op = alu_slt;
          3'b100:  ctrl_d.alu_op = alu_xor;
          3'b110:  ctrl_d.alu_op = alu_or;
          3'b111:  ctrl_d.alu_op = alu_and;
          default: ctrl_d.alu_op = alu_add;
        endcase
      end
      opc_op_imm: begin
        ctrl_d.alu_src_imm = 1'b1;
        ctrl_d.reg_write   = 1'b1;
      end
      opc_lui: begin
        imm_sel            = imm_u;
        ctrl_d.alu_op      = alu_pass_b;
        ctrl_d.alu_src_imm = 1'b1;
        ctrl_d.reg_write   = 1'b1;
      end
      opc_load: begin
        ctrl_d.alu_src_imm = 1'b1;
        ctrl_d.mem_read    = 1'b1;
        ctrl_d.result_sel  = res_mem;
        ctrl_d.reg_write   = 1'b1;
      end
      opc_store: begin
        imm_sel            = imm_s;
        ctrl_d.alu_src_imm = 1'b1;
        ctrl_d.mem_write   = 1'b1;
      end
      opc_branch: begin
        // compare by subtraction, zero flag decides
        imm_sel          = imm_b;
        ctrl_d.alu_op    = alu_sub;
        ctrl_d.is_branch = 1'b1;
        ctrl_d.branch_ne = (funct3 == 3'b001);
      end
      opc_jal: begin
        imm_sel           = imm_j;
        ctrl_d.is_jal     = 1'b1;
        ctrl_d.result_sel = res_pc_plus4;
        ctrl_d.reg_write  = 1'b1;
      end
      default: ;
    endcase
  end

  // execute control, bubble on flush
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_ctrl <= '0;
    end else if (hz.flush_e) begin
      ex_ctrl <= '0;
    end else begin
      ex_ctrl <= ctrl_d;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mem_ctrl <= '0;
      wb_ctrl  <= '0;
    end else begin
      mem_ctrl.result_sel <= ex_ctrl.result_sel;
      mem_ctrl.mem_write  <= ex_ctrl.mem_write;
      mem_ctrl.mem_read   <= ex_ctrl.mem_read;
      mem_ctrl.reg_write  <= ex_ctrl.reg_write;
      wb_ctrl.result_sel  <= mem_ctrl.result_sel;
      wb_ctrl.reg_write   <= mem_ctrl.reg_write;
    end
  end

  // branch resolved in execute
  assign pc_redirect = ex_ctrl.is_jal | (ex_ctrl.is_branch & (zero_e ^ ex_ctrl.branch_ne));

endmodule

//--- datapath.sv
`timescale 1ns/1ps

module datapath (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic [rv_pkg::xlen-1:0] instr_data,
  input  logic [rv_pkg::xlen-1:0] data_rdata,
  input  rv_pkg::imm_sel_e        imm_sel,
  input  rv_pkg::ex_ctrl_t        ex_ctrl,
  input  rv_pkg::mem_ctrl_t       mem_ctrl,
  input  rv_pkg::wb_ctrl_t        wb_ctrl,
  input  logic                    pc_redirect,
  input  rv_pkg::hazard_t         hz,
  output logic [rv_pkg::xlen-1:0] instr_addr,
  output logic [rv_pkg::xlen-1:0] data_addr,
  output logic [rv_pkg::xlen-1:0] data_wdata,
  output logic [rv_pkg::xlen-1:0] instr_d,
  output rv_pkg::dp_status_t      status
);
  import rv_pkg::*;

  // fetch
  logic [xlen-1:0] pc_f, pc_plus4_f, pc_next;
  // decode
  logic [xlen-1:0] pc_d, pc_plus4_d, imm_d, rd1_d, rd2_d;
  logic [reg_addr_w-1:0] rs1_d, rs2_d, rd_d;
  // execute
  logic [xlen-1:0] pc_e, pc_plus4_e, imm_e, rd1_e, rd2_e;
  logic [xlen-1:0] src_a_e, fwd_b_e, alu_b_e, alu_e, target_e;
  logic [reg_addr_w-1:0] rs1_e, rs2_e, rd_e;
  // memory
  logic [xlen-1:0] alu_m, wdata_m, pc_plus4_m;
  logic [reg_addr_w-1:0] rd_m;
  // writeback
  logic [xlen-1:0] alu_w, rdata_w, pc_plus4_w, result_w;
  logic [reg_addr_w-1:0] rd_w;

  logic [xlen-1:0] regs [32];

  function automatic logic [xlen-1:0] fwd_mux(input fwd_sel_e sel,
                                               input logic [xlen-1:0] reg_val,
                                               input logic [xlen-1:0] mem_val,
                                               input logic [xlen-1:0] wb_val);
    case (sel)
      fwd_from_mem: return mem_val;
      fwd_from_wb:  return wb_val;
      default:      return reg_val;
    endcase
  endfunction

  // fetch stage
  assign pc_plus4_f = pc_f + xlen'(4);
  assign pc_next    = pc_redirect ? target_e : pc_plus4_f;
  assign instr_addr = pc_f;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc_f <= reset_pc;
    end else if (pc_redirect || !hz.stall_f) begin
      pc_f <= pc_next;
    end
  end

  // decode register loads a nop on flush
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      instr_d <= nop_instr;
    end else if (hz.flush_d) begin
      instr_d <= nop_instr;
    end else if (!hz.stall_d) begin
      instr_d <= instr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!hz.stall_d) begin
      pc_d       <= pc_f;
      pc_plus4_d <= pc_plus4_f;
    end
  end

  assign rs1_d = instr_d[19:15];
  assign rs2_d = instr_d[24:20];
  assign rd_d  = instr_d[11:7];

  // register file with x0 reading as zero
  always_ff @(posedge clk) begin
    if (wb_ctrl.reg_write && rd_w != '0) begin
      regs[rd_w] <= result_w;
    end
  end

  // write-through so decode sees the value written this cycle
  assign rd1_d = (rs1_d == '0) ? '0 :
                 (wb_ctrl.reg_write && rd_w == rs1_d) ? result_w : regs[rs1_d];
  assign rd2_d = (rs2_d == '0) ? '0 :
                 (wb_ctrl.reg_write && rd_w == rs2_d) ? result_w : regs[rs2_d];

  always_comb begin
    case (imm_sel)
      imm_s:   imm_d = {{20{instr_d[31]}}, instr_d[31:25], instr_d[11:7]};
      imm_b:   imm_d = {{19{instr_d[31]}}, instr_d[31], instr_d[7],
                        instr_d[30:25], instr_d[11:8], 1'b0};
      imm_u:   imm_d = {instr_d[31:12], 12'b0};
      imm_j:   imm_d = {{11{instr_d[31]}}, instr_d[31], instr_d[19:12],
                        instr_d[20], instr_d[30:21], 1'b0};
      default: imm_d = {{20{instr_d[31]}}, instr_d[31:20]};
    endcase
  end

  // execute register indices cleared so a bubble never matches for forwarding
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rs1_e <= '0;
      rs2_e <= '0;
      rd_e  <= '0;
    end else if (hz.flush_e) begin
      rs1_e <= '0;
      rs2_e <= '0;
      rd_e  <= '0;
    end else begin
      rs1_e <= rs1_d;
      rs2_e <= rs2_d;
      rd_e  <= rd_d;
    end
  end

  always_ff @(posedge clk) begin
    pc_e       <= pc_d;
    pc_plus4_e <= pc_plus4_d;
    imm_e      <= imm_d;
    rd1_e      <= rd1_d;
    rd2_e      <= rd2_d;
  end

  // operand selection
  assign src_a_e  = fwd_mux(hz.fwd_a, rd1_e, alu_m, result_w);
  assign fwd_b_e  = fwd_mux(hz.fwd_b, rd2_e, alu_m, result_w);
  assign alu_b_e  = ex_ctrl.alu_src_imm ? imm_e : fwd_b_e;
  assign target_e = pc_e + imm_e;

  always_comb begin
    case (ex_ctrl.alu_op)
      alu_sub:    alu_e = src_a_e - alu_b_e;
      alu_and:    alu_e = src_a_e & alu_b_e;
      alu_or:     alu_e = src_a_e | alu_b_e;
      alu_xor:    alu_e = src_a_e ^ alu_b_e;
      alu_slt:    alu_e = xlen'($signed(src_a_e) < $signed(alu_b_e));
      alu_pass_b: alu_e = alu_b_e;
      default:    alu_e = src_a_e + alu_b_e;
    endcase
  end

  // memory and writeback registers
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_m <= '0;
      rd_w <= '0;
    end else begin
      rd_m <= rd_e;
      rd_w <= rd_m;
    end
  end

  always_ff @(posedge clk) begin
    alu_m      <= alu_e;
    wdata_m    <= fwd_b_e;
    pc_plus4_m <= pc_plus4_e;
    alu_w      <= alu_m;
    rdata_w    <= mem_ctrl.mem_read ? data_rdata : '0;
    pc_plus4_w <= pc_plus4_m;
  end

  assign data_addr  = alu_m;
  assign data_wdata = wdata_m;

  always_comb begin
    case (wb_ctrl.result_sel)
      res_mem:      result_w = rdata_w;
      res_pc_plus4: result_w = pc_plus4_w;
      default:      result_w = alu_w;
    endcase
  end

  always_comb begin
    status.rs1_d  = rs1_d;
    status.rs2_d  = rs2_d;
    status.rs1_e  = rs1_e;
    status.rs2_e  = rs2_e;
    status.rd_e   = rd_e;
    status.rd_m   = rd_m;
    status.rd_w   = rd_w;
    status.zero_e = (alu_e == '0);
  end

endmodule

//--- hazard.sv
`timescale 1ns/1ps

module hazard (
  input  rv_pkg::dp_status_t status,
  input  rv_pkg::ex_ctrl_t   ex_ctrl,
  input  logic               mem_reg_write,
  input  logic               wb_reg_write,
  input  logic               pc_redirect,
  output rv_pkg::hazard_t    hz
);
  import rv_pkg::*;

  logic load_use;

  // the younger producer in memory wins over writeback
  function automatic fwd_sel_e fwd_select(input logic [reg_addr_w-1:0] rs,
                                          input logic [reg_addr_w-1:0] rd_m,
                                          input logic                  we_m,
                                          input logic [reg_addr_w-1:0] rd_w,
                                          input logic                  we_w);
    if (we_m && rd_m != '0 && rd_m == rs) begin
      return fwd_from_mem;
    end else if (we_w && rd_w != '0 && rd_w == rs) begin
      return fwd_from_wb;
    end
    return fwd_reg;
  endfunction

  // load result not ready until writeback
  assign load_use = ex_ctrl.mem_read && status.rd_e != '0 &&
                    (status.rd_e == status.rs1_d || status.rd_e == status.rs2_d);

  always_comb begin
    hz = '0;
    hz.fwd_a   = fwd_select(status.rs1_e, status.rd_m, mem_reg_write,
                            status.rd_w, wb_reg_write);
    hz.fwd_b   = fwd_select(status.rs2_e, status.rd_m, mem_reg_write,
                            status.rd_w, wb_reg_write);
    hz.stall_f = load_use;
    hz.stall_d = load_use;
    hz.flush_d = pc_redirect;
    hz.flush_e = load_use | pc_redirect;
  end

endmodule

//--- rv_pkg.sv
package rv_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;

  localparam logic [xlen-1:0] reset_pc = '0;
  // addi x0, x0, 0
  localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;

  // opcode field values of the supported subset
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui    = 7'b0110111,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_pass_b
  } alu_op_e;

  typedef enum logic [2:0] {
    imm_i, imm_s, imm_b, imm_u, imm_j
  } imm_sel_e;

  typedef enum logic [1:0] {
    res_alu, res_mem, res_pc_plus4
  } result_sel_e;

  typedef enum logic [1:0] {
    fwd_reg, fwd_from_mem, fwd_from_wb
  } fwd_sel_e;

  typedef struct packed {
    alu_op_e     alu_op;
    logic        alu_src_imm;
    logic        is_branch;
    logic        branch_ne;
    logic        is_jal;
    result_sel_e result_sel;
    logic        mem_write;
    logic        mem_read;
    logic        reg_write;
  } ex_ctrl_t;

  typedef struct packed {
    result_sel_e result_sel;
    logic        mem_write;
    logic        mem_read;
    logic        reg_write;
  } mem_ctrl_t;

  typedef struct packed {
    result_sel_e result_sel;
    logic        reg_write;
  } wb_ctrl_t;

  // register indices per stage, for hazard detection
  typedef struct packed {
    logic [reg_addr_w-1:0] rs1_d;
    logic [reg_addr_w-1:0] rs2_d;
    logic [reg_addr_w-1:0] rs1_e;
    logic [reg_addr_w-1:0] rs2_e;
    logic [reg_addr_w-1:0] rd_e;
    logic [reg_addr_w-1:0] rd_m;
    logic [reg_addr_w-1:0] rd_w;
    logic                  zero_e;
  } dp_status_t;

  typedef struct packed {
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
    logic     stall_f;
    logic     stall_d;
    logic     flush_d;
    logic     flush_e;
  } hazard_t;

endpackage

//--- tb.f
rv_pkg.sv
datapath.sv
controller.sv
hazard.sv
top.sv
tb_top.sv

//--- tb_top.sv
`timescale 1ns/1ps

module tb_top;
  import rv_pkg::*;

  localparam int cycle_limit = 2000;
  localparam int test_budget = 150;
  localparam logic [31:0] sentinel_addr = 32'h100;

  logic        clk;
  logic        arst_n;
  logic [31:0] instr_addr, instr_data, data_addr, data_wdata, data_rdata;
  logic        data_we;

  logic [31:0] imem [64];
  logic [31:0] dmem [64];
  logic [31:0] store_addr_q[$], store_data_q[$];
  logic [31:0] exp_addr_q[$], exp_data_q[$];
  int          prog_len, cycle_count, checks, errors, err_start;
  int          tests_run, tests_failed;
  integer      seed;

  top dut_i (
    .clk(clk), .arst_n(arst_n),
    .instr_addr(instr_addr), .instr_data(instr_data),
    .data_addr(data_addr), .data_wdata(data_wdata),
    .data_we(data_we), .data_rdata(data_rdata)
  );

  // both memories answer in the same cycle
  assign instr_data = imem[instr_addr[7:2]];
  assign data_rdata = dmem[data_addr[7:2]];

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: run exceeded %0d cycles", cycle_limit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // RV32I instruction formats
  function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
                                         input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input int imm, input int rs1, input int f3,
                                         input int rd, input int opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
                                         input int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
            7'b1100011};
  endfunction

  function automatic logic [31:0] u_type(input int imm, input int rd);
    return {imm[31:12], rd[4:0], 7'b0110111};
  endfunction

  function automatic logic [31:0] j_type(input int imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
  endfunction

  function automatic logic [31:0] addi_word(input int rd, input int rs1, input int imm);
    return i_type(imm, rs1, 0, rd, 7'h13);
  endfunction

  // loads and stores are based on x0
  function automatic logic [31:0] load_word(input int rd, input int offset);
    return i_type(offset, 0, 2, rd, 7'h03);
  endfunction

  function automatic logic [31:0] store_word(input int rs2, input int offset);
    return s_type(offset, rs2, 0);
  endfunction

  task automatic emit(input logic [31:0] instr);
    imem[prog_len[5:0]] = instr;
    prog_len++;
  endtask

  // upper part rounded so the sign-extended low part adds back
  task automatic load_const(input int rd, input logic [31:0] value);
    emit(u_type(value + 32'h800, rd));
    emit(addi_word(rd, rd, value));
  endtask

  task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
    exp_addr_q.push_back(addr);
    exp_data_q.push_back(data);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got,
                          input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic start_test;
    err_start = errors;
    prog_len  = 0;
    store_addr_q.delete();
    store_data_q.delete();
    exp_addr_q.delete();
    exp_data_q.delete();
    for (int i = 0; i < 64; i++) begin
      imem[i[5:0]] = addi_word(0, 0, 0);
      dmem[i[5:0]] = 32'hd0d0_0000 | 32'(i * 4);
    end
  endtask

  task automatic pulse_reset;
    @(negedge clk);
    arst_n = 1'b0;
    repeat (2) @(negedge clk);
    arst_n = 1'b1;
  endtask

  // stores land at the falling edge and the sentinel store ends the program
  task automatic run_program(output bit finished);
    int n;
    finished = 1'b0;
    n = 0;
    while (!finished && n < test_budget) begin
      @(negedge clk);
      n++;
      if (data_we) begin
        if (data_addr == sentinel_addr) begin
          finished = 1'b1;
        end else begin
          dmem[data_addr[7:2]] = data_wdata;
          store_addr_q.push_back(data_addr);
          store_data_q.push_back(data_wdata);
        end
      end
    end
  endtask

  task automatic run_and_check(input string name);
    bit finished;
    int n;
    emit(store_word(0, sentinel_addr));
    run_program(finished);
    if (!finished) begin
      errors++;
      $display("%s: program did not finish within %0d cycles", name, test_budget);
    end
    check_eq("store count", 32'(store_addr_q.size()), 32'(exp_addr_q.size()));
    n = (store_addr_q.size() < exp_addr_q.size()) ? store_addr_q.size() : exp_addr_q.size();
    for (int i = 0; i < n; i++) begin
      check_eq($sformatf("data_addr[%0d]", i), store_addr_q[i], exp_addr_q[i]);
      check_eq($sformatf("data_wdata[%0d]", i), store_data_q[i], exp_data_q[i]);
    end
    tests_run++;
    if (errors == err_start) begin
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail with %0d errors", name, errors - err_start);
    end
  endtask

  task automatic test_reset;
    start_test();
    pulse_reset();
    check_eq("instr_addr", instr_addr, reset_pc);
    check_eq("data_we", 32'(data_we), 32'h0);
    run_and_check("reset");
  endtask

  task automatic test_alu(input int round);
    logic [31:0] a, b, imm, e3, e4, e5, e6, e7;
    a   = $random(seed);
    b   = $random(seed);
    imm = $random(seed);
    start_test();
    load_const(1, a);
    load_const(2, b);
    // each result feeds the next one directly
    emit(r_type(0, 2, 1, 0, 3));
    emit(r_type(32, 2, 3, 0, 4));
    emit(r_type(0, 3, 4, 7, 5));
    emit(r_type(0, 1, 5, 6, 6));
    emit(r_type(0, 2, 6, 4, 7));
    emit(r_type(0, 2, 1, 2, 8));
    emit(r_type(0, 1, 2, 2, 9));
    emit(addi_word(10, 7, imm));
    for (int k = 3; k <= 10; k++) begin
      emit(store_word(k, 4 * (k - 3)));
    end
    e3 = a + b;
    e4 = e3 - b;
    e5 = e4 & e3;
    e6 = e5 | a;
    e7 = e6 ^ b;
    expect_store(32'h00, e3);
    expect_store(32'h04, e4);
    expect_store(32'h08, e5);
    expect_store(32'h0c, e6);
    expect_store(32'h10, e7);
    expect_store(32'h14, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
    expect_store(32'h18, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
    expect_store(32'h1c, e7 + {{20{imm[11]}}, imm[11:0]});
    pulse_reset();
    run_and_check($sformatf("alu round %0d", round));
  endtask

  task automatic test_load_store;
    logic [31:0] v [4];
    start_test();
    for (int i = 0; i < 4; i++) begin
      v[i] = $random(seed);
      load_const(i + 1, v[i]);
    end
    for (int i = 0; i < 4; i++) begin
      emit(store_word(i + 1, 'h40 + 4 * i));
      expect_store(32'h40 + 32'(4 * i), v[i]);
    end
    // loaded values used right away
    emit(load_word(5, 'h40));
    emit(r_type(0, 1, 5, 0, 6));
    emit(load_word(7, 'h44));
    emit(load_word(8, 'h48));
    emit(r_type(0, 8, 7, 0, 9));
    emit(store_word(6, 'h50));
    emit(store_word(9, 'h54));
    emit(load_word(10, 'h4c));
    emit(store_word(10, 'h58));
    expect_store(32'h50, v[0] + v[0]);
    expect_store(32'h54, v[1] + v[2]);
    expect_store(32'h58, v[3]);
    pulse_reset();
    run_and_check("load store");
  endtask

  task automatic test_branches;
    start_test();
    emit(addi_word(1, 0, 5));
    emit(addi_word(2, 0, 5));
    emit(addi_word(3, 0, 7));
    emit(addi_word(5, 0, 'ha1));
    emit(addi_word(6, 0, 'ha2));
    emit(addi_word(7, 0, 'ha3));
    // beq taken over three marker stores
    emit(b_type(16, 2, 1, 0));
    emit(store_word(5, 'h20));
    emit(store_word(6, 'h24));
    emit(store_word(7, 'h28));
    emit(store_word(3, 'h2c));
    // bne on equal values falls through
    emit(b_type(8, 2, 1, 1));
    emit(store_word(5, 'h30));
    emit(b_type(8, 3, 1, 1));
    emit(store_word(6, 'h34));
    emit(store_word(7, 'h38));
    expect_store(32'h2c, 32'd7);
    expect_store(32'h30, 32'ha1);
    expect_store(32'h38, 32'ha3);
    pulse_reset();
    run_and_check("branches");
  endtask

  task automatic test_jal;
    int jal1, jal2;
    start_test();
    emit(addi_word(5, 0, 'h51));
    emit(addi_word(6, 0, 'h52));
    jal1 = prog_len;
    emit(j_type(12, 1));
    emit(store_word(5, 'h60));
    emit(store_word(6, 'h64));
    emit(store_word(1, 'h68));
    jal2 = prog_len;
    emit(j_type(8, 2));
    emit(store_word(5, 'h6c));
    // link value used by the first instruction at the target
    emit(addi_word(3, 2, 4));
    emit(store_word(3, 'h70));
    expect_store(32'h68, 32'(jal1 * 4 + 4));
    expect_store(32'h70, 32'(jal2 * 4 + 8));
    pulse_reset();
    run_and_check("jal");
  endtask

  initial begin
    seed   = 32'h4764ce0b;
    arst_n = 1'b0;
    start_test();
    repeat (4) @(negedge clk);
    arst_n = 1'b1;
    test_reset();
    test_alu(1);
    test_alu(2);
    test_load_store();
    test_branches();
    test_jal();
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- top.sv
`timescale 1ns/1ps

module top (
  input  logic                    clk,
  input  logic                    arst_n,
  output logic [rv_pkg::xlen-1:0] instr_addr,
  input  logic [rv_pkg::xlen-1:0] instr_data,
  output logic [rv_pkg::xlen-1:0] data_addr,
  output logic [rv_pkg::xlen-1:0] data_wdata,
  output logic                    data_we,
  input  logic [rv_pkg::xlen-1:0] data_rdata
);
  import rv_pkg::*;

  // from datapath
  logic [xlen-1:0] instr_d;
  dp_status_t      status;
  // from controller
  imm_sel_e        imm_sel;
  ex_ctrl_t        ex_ctrl;
  mem_ctrl_t       mem_ctrl;
  wb_ctrl_t        wb_ctrl;
  logic            pc_redirect;
  // from hazard
  hazard_t         hz;

  assign data_we = mem_ctrl.mem_write;

  datapath datapath_i (
    .clk(clk), .arst_n(arst_n),
    .instr_data(instr_data), .data_rdata(data_rdata),
    .imm_sel(imm_sel), .ex_ctrl(ex_ctrl), .mem_ctrl(mem_ctrl), .wb_ctrl(wb_ctrl),
    .pc_redirect(pc_redirect), .hz(hz),
    .instr_addr(instr_addr), .data_addr(data_addr), .data_wdata(data_wdata),
    .instr_d(instr_d), .status(status)
  );

  controller controller_i (
    .clk(clk), .arst_n(arst_n),
    .instr_d(instr_d), .zero_e(status.zero_e), .hz(hz),
    .imm_sel(imm_sel), .ex_ctrl(ex_ctrl), .mem_ctrl(mem_ctrl), .wb_ctrl(wb_ctrl),
    .pc_redirect(pc_redirect)
  );

  hazard hazard_i (
    .status(status), .ex_ctrl(ex_ctrl),
    .mem_reg_write(mem_ctrl.reg_write), .wb_reg_write(wb_ctrl.reg_write),
    .pc_redirect(pc_redirect),
    .hz(hz)
  );

endmodule
